/* tb/bomb_audio_trace.txt */
# load m t o | time m t o | req s | now s | await s | hold s n | wait n
# sound s half toggles | ticks n | expire | exp_is b
time 0 0 0
now idle
exp_is 0
req error
sound error 5 12
req boom
sound boom 7 16
req puzzle
sound puzzle 4 8
req boom
wait 20
req error
now error
sound error 5 12
req puzzle
wait 10
req error
now error
sound error 5 12
req error
wait 10
req puzzle
hold error 20
await idle
hold idle 30
load 2 0 5
time 2 0 5
wait 1210
time 1 5 9
load 0 1 0
wait 210
time 0 0 9
load 0 4 5
sound tick 3 6
await tick
req error
now error
sound error 5 12
load 0 4 5
wait 200
ticks 1
load 0 2 5
wait 200
ticks 2
load 0 1 5
wait 200
ticks 4
load 0 0 2
expire
time 0 0 0
ticks 0
time 0 0 0
exp_is 1
load 0 0 5
exp_is 0
time 0 0 5

/* src.f */
+incdir+include
source/bomb_audio_pkg.sv
source/countdown_timer.sv
source/audio_sm.sv
source/tone_gen.sv
source/bomb_audio_top.sv
tb/tb_clock_gen.sv
tb/bomb_audio_chk.sv
tb/bomb_audio_tb.sv

/* Bender.yml */
package:
  name: bomb_audio

export_include_dirs:
  - include

sources:
  - files:
      - source/bomb_audio_pkg.sv
      - source/countdown_timer.sv
      - source/audio_sm.sv
      - source/tone_gen.sv
      - source/bomb_audio_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/bomb_audio_chk.sv
      - tb/bomb_audio_tb.sv

/* tb/bomb_audio_tb.sv */
`timescale 1ns/1ps

`include "bomb_audio_config.svh"

module bomb_audio_tb;

  localparam int WAIT_LIMIT = 4 * `SEC_CYCLES;

  logic clk;
  logic nrst;
  logic load;
  logic error;
  logic puzzle_clear;
  logic game_clear;
  bomb_audio_pkg::game_time_t start_time;
  logic audio;
  logic expired;
  bomb_audio_pkg::sound_e cur_sound;
  bomb_audio_pkg::game_time_t time_left;

  // cur_sound one sample back, to spot a fresh start
  bomb_audio_pkg::sound_e last_sound;

  tb_clock_gen i_clk (
    .clk (clk)
  );

  bomb_audio_top i_dut (
    .clk          (clk),
    .nrst         (nrst),
    .load         (load),
    .error        (error),
    .puzzle_clear (puzzle_clear),
    .game_clear   (game_clear),
    .start_time   (start_time),
    .audio        (audio),
    .expired      (expired),
    .cur_sound    (cur_sound),
    .time_left    (time_left)
  );

  bind bomb_audio_top bomb_audio_chk i_chk (.*);

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic value_fail(input string msg);
    stop_run($sformatf("Fail %0t: %s", $time, msg));
  endtask

  // drive and sample point 10 ns past the rising edge
  task automatic next_cycle();
    last_sound = cur_sound;
    @(posedge clk);
    #10;
  endtask

  task automatic check_sound(input bomb_audio_pkg::sound_e got,
                             input bomb_audio_pkg::sound_e exp, input string what);
    if (got !== exp) begin
      value_fail($sformatf("%s: cur_sound %s, expected %s", what, got.name(), exp.name()));
    end
  endtask

  task automatic check_time(input bomb_audio_pkg::game_time_t got,
                            input bomb_audio_pkg::game_time_t exp);
    if (got !== exp) begin
      value_fail($sformatf("time_left %0d:%0d%0d, expected %0d:%0d%0d", got.minutes,
                           got.sec_ten, got.sec_one, exp.minutes, exp.sec_ten, exp.sec_one));
    end
  endtask

  task automatic check_tone(input bomb_audio_pkg::tone_t got, input bomb_audio_pkg::tone_t exp);
    if (got !== exp) begin
      value_fail($sformatf("audio half period %0d, %0d edges, expected %0d and %0d",
                           got.half_period, got.toggles, exp.half_period, exp.toggles));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_fail($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      value_fail($sformatf("%s: counted %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic parse_sound(input logic [63:0] nm, output bomb_audio_pkg::sound_e s);
    case (nm)
      "idle":   s = bomb_audio_pkg::snd_idle;
      "error":  s = bomb_audio_pkg::snd_error;
      "boom":   s = bomb_audio_pkg::snd_boom;
      "puzzle": s = bomb_audio_pkg::snd_puzzle;
      "tick":   s = bomb_audio_pkg::snd_tick;
      default:  stop_run($sformatf("unknown sound name %0s in trace", nm));
    endcase
  endtask

  // one cycle request strobe
  task automatic pulse_request(input bomb_audio_pkg::sound_e s);
    case (s)
      bomb_audio_pkg::snd_error:  error = 1'b1;
      bomb_audio_pkg::snd_boom:   game_clear = 1'b1;
      bomb_audio_pkg::snd_puzzle: puzzle_clear = 1'b1;
      default: stop_run("trace asks for a sound that has no request input");
    endcase
    next_cycle();
    error = 1'b0;
    game_clear = 1'b0;
    puzzle_clear = 1'b0;
  endtask

  task automatic apply_load(input bomb_audio_pkg::game_time_t t);
    start_time = t;
    load = 1'b1;
    next_cycle();
    load = 1'b0;
  endtask

  task automatic await_sound(input bomb_audio_pkg::sound_e s);
    int n;
    n = 0;
    while (cur_sound !== s) begin
      if (n == WAIT_LIMIT) begin
        stop_run($sformatf("timed out waiting for sound %s", s.name()));
      end
      next_cycle();
      n++;
    end
  endtask

  // a sound that begins at this sample, not one already playing
  task automatic await_start(input bomb_audio_pkg::sound_e s);
    int n;
    n = 0;
    while (!(cur_sound === s && last_sound !== s)) begin
      if (n == WAIT_LIMIT) begin
        stop_run($sformatf("timed out waiting for sound %s to start", s.name()));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic await_expired();
    int n;
    n = 0;
    while (expired !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        stop_run("timed out waiting for the timer to expire");
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic hold_sound(input bomb_audio_pkg::sound_e s, input int cycles);
    repeat (cycles) begin
      next_cycle();
      check_sound(cur_sound, s, "held sound");
    end
  endtask

  // edges and spacing of audio while the sound is active
  task automatic measure_sound(input bomb_audio_pkg::sound_e s,
                               input bomb_audio_pkg::tone_t exp);
    int n;
    int since;
    int spacing;
    int edges;
    logic prev;
    logic uneven;
    bomb_audio_pkg::tone_t got;
    await_start(s);
    // old sound may leave audio high
    // the new one always rises first
    prev = 1'b0;
    n = 0;
    since = 0;
    spacing = 0;
    edges = 0;
    uneven = 1'b0;
    next_cycle();
    while (cur_sound === s) begin
      if (n == WAIT_LIMIT) begin
        stop_run($sformatf("sound %s did not end in time", s.name()));
      end
      since++;
      if (audio !== prev) begin
        edges++;
        if (edges == 2) begin
          spacing = since;
        end else if (edges > 2 && since != spacing) begin
          uneven = 1'b1;
        end
        since = 0;
      end
      prev = audio;
      next_cycle();
      n++;
    end
    got.half_period = spacing[7:0];
    got.toggles = edges[5:0];
    check_tone(got, exp);
    check_flag(uneven, 1'b0, "uneven audio half period");
    check_flag(audio, 1'b0, "audio after sound");
    check_sound(cur_sound, bomb_audio_pkg::snd_idle, "after sound");
  endtask

  // tick sound starts in one game second
  task automatic count_ticks(input int exp);
    int n;
    bomb_audio_pkg::sound_e prev;
    n = 0;
    prev = cur_sound;
    repeat (`SEC_CYCLES) begin
      next_cycle();
      if (cur_sound == bomb_audio_pkg::snd_tick && prev != bomb_audio_pkg::snd_tick) begin
        n++;
      end
      prev = cur_sound;
    end
    check_count(n, exp, "tick starts per second");
  endtask

  task automatic run_command(input int fd, input logic [95:0] cmd);
    int r;
    int a;
    int b;
    int c;
    logic [63:0] nm;
    logic [8*200-1:0] rest;
    bomb_audio_pkg::sound_e snd;
    bomb_audio_pkg::tone_t tn;
    bomb_audio_pkg::game_time_t t;
    case (cmd)
      "#": r = $fgets(rest, fd);
      "load", "time": begin
        r = $fscanf(fd, "%d %d %d", a, b, c);
        t.minutes = a[2:0];
        t.sec_ten = b[2:0];
        t.sec_one = c[3:0];
        if (cmd == "load") begin
          apply_load(t);
        end else begin
          check_time(time_left, t);
        end
      end
      "req", "now", "await": begin
        r = $fscanf(fd, "%s", nm);
        parse_sound(nm, snd);
        if (cmd == "req") begin
          pulse_request(snd);
        end else if (cmd == "now") begin
          check_sound(cur_sound, snd, "current sound");
        end else begin
          await_sound(snd);
        end
      end
      "hold": begin
        r = $fscanf(fd, "%s %d", nm, a);
        parse_sound(nm, snd);
        hold_sound(snd, a);
      end
      "sound": begin
        r = $fscanf(fd, "%s %d %d", nm, a, b);
        parse_sound(nm, snd);
        tn.half_period = a[7:0];
        tn.toggles = b[5:0];
        measure_sound(snd, tn);
      end
      "wait": begin
        r = $fscanf(fd, "%d", a);
        repeat (a) next_cycle();
      end
      "ticks": begin
        r = $fscanf(fd, "%d", a);
        count_ticks(a);
      end
      "expire": await_expired();
      "exp_is": begin
        r = $fscanf(fd, "%d", a);
        check_flag(expired, a[0], "expired");
      end
      default: stop_run($sformatf("unknown trace command %0s", cmd));
    endcase
  endtask

  initial begin
    int fd;
    int r;
    logic [95:0] cmd;
    nrst = 1'b0;
    load = 1'b0;
    error = 1'b0;
    puzzle_clear = 1'b0;
    game_clear = 1'b0;
    start_time = '0;
    last_sound = bomb_audio_pkg::snd_idle;
    repeat (10) @(posedge clk);
    #10;
    nrst = 1'b1;
    fd = $fopen("tb/bomb_audio_trace.txt", "r");
    if (fd == 0) begin
      stop_run("could not open tb/bomb_audio_trace.txt");
    end
    while (!$feof(fd)) begin
      cmd = '0;
      r = $fscanf(fd, "%s", cmd);
      if (r == 1) begin
        run_command(fd, cmd);
      end
    end
    $fclose(fd);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* tb/bomb_audio_chk.sv */
`timescale 1ns/1ps

module bomb_audio_chk (
  input logic                       clk,
  input logic                       nrst,
  input logic                       audio,
  input logic                       expired,
  input logic                       beat,
  input logic                       beat_fast,
  input logic                       beat_faster,
  input bomb_audio_pkg::sound_e     cur_sound,
  input bomb_audio_pkg::game_time_t time_left
);

  // speaker quiet with no active sound
  a_quiet_idle: assert property (
    @(posedge clk) disable iff (!nrst)
      (cur_sound == bomb_audio_pkg::snd_idle) |-> !audio
  ) else $error("audio high while no sound is active");

  // expired only at 0:00
  a_expired_zero: assert property (
    @(posedge clk) disable iff (!nrst)
      expired |-> (time_left == '0)
  ) else $error("expired set with time left on the clock");

  // timer stopped, so no beats
  a_no_beat: assert property (
    @(posedge clk) disable iff (!nrst)
      expired |-> !(beat || beat_fast || beat_faster)
  ) else $error("beat strobe fired after the timer expired");

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // 100 ns period, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

endmodule

/* source/bomb_audio_top.sv */
`timescale 1ns/1ps

module bomb_audio_top (
  input  logic                       clk,
  input  logic                       nrst,
  input  logic                       load,
  input  logic                       error,
  input  logic                       puzzle_clear,
  input  logic                       game_clear,
  input  bomb_audio_pkg::game_time_t start_time,
  output logic                       audio,
  output logic                       expired,
  output bomb_audio_pkg::sound_e     cur_sound,
  output bomb_audio_pkg::game_time_t time_left
);

  // timer to sound picker
  logic beat;
  logic beat_fast;
  logic beat_faster;

  // sound picker to tone generator and back
  logic tone_start;
  logic tone_done;
  bomb_audio_pkg::tone_t tone;

  countdown_timer u_timer (
    .clk         (clk),
    .nrst        (nrst),
    .load        (load),
    .start_time  (start_time),
    .time_left   (time_left),
    .beat        (beat),
    .beat_fast   (beat_fast),
    .beat_faster (beat_faster),
    .expired     (expired)
  );

  audio_sm u_sm (
    .clk          (clk),
    .nrst         (nrst),
    .error        (error),
    .puzzle_clear (puzzle_clear),
    .game_clear   (game_clear),
    .beat         (beat),
    .beat_fast    (beat_fast),
    .beat_faster  (beat_faster),
    .time_left    (time_left),
    .tone_done    (tone_done),
    .cur_sound    (cur_sound),
    .tone_start   (tone_start),
    .tone         (tone)
  );

  tone_gen u_tone (
    .clk        (clk),
    .nrst       (nrst),
    .tone_start (tone_start),
    .tone       (tone),
    .audio      (audio),
    .tone_done  (tone_done)
  );

endmodule

/* source/tone_gen.sv */
`timescale 1ns/1ps

module tone_gen (
  input  logic                  clk,
  input  logic                  nrst,
  input  logic                  tone_start,
  input  bomb_audio_pkg::tone_t tone,
  output logic                  audio,
  output logic                  tone_done
);

  bomb_audio_pkg::tone_t tone_q;
  logic busy;
  logic [7:0] hp_cnt;
  logic [5:0] edge_cnt;
  logic [5:0] edge_nxt;
  logic hp_wrap;

  assign hp_wrap = (hp_cnt == tone_q.half_period - 8'd1);
  assign edge_nxt = edge_cnt + 6'd1;

  // descriptor held for the whole sound
  always_ff @(posedge clk) begin
    if (tone_start) begin
      tone_q <= tone;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      busy      <= 1'b0;
      audio     <= 1'b0;
      tone_done <= 1'b0;
      hp_cnt    <= '0;
      edge_cnt  <= '0;
    end else begin
      tone_done <= 1'b0;
      if (tone_start) begin
        // first rising edge right away, counts as edge one
        // also the restart path when preempted
        busy     <= 1'b1;
        audio    <= 1'b1;
        hp_cnt   <= '0;
        edge_cnt <= 6'd1;
      end else if (busy) begin
        if (hp_wrap) begin
          hp_cnt   <= '0;
          audio    <= ~audio;
          edge_cnt <= edge_nxt;
          if (edge_nxt == tone_q.toggles) begin
            // last edge, even count so audio is low here
            busy      <= 1'b0;
            audio     <= 1'b0;
            tone_done <= 1'b1;
          end
        end else begin
          hp_cnt <= hp_cnt + 8'd1;
        end
      end
    end
  end

endmodule

/* source/audio_sm.sv */
`timescale 1ns/1ps

`include "bomb_audio_config.svh"

module audio_sm (
  input  logic                     clk,
  input  logic                     nrst,
  input  logic                     error,
  input  logic                     puzzle_clear,
  input  logic                     game_clear,
  input  logic                     beat,
  input  logic                     beat_fast,
  input  logic                     beat_faster,
  input  bomb_audio_pkg::game_time_t time_left,
  input  logic                     tone_done,
  output bomb_audio_pkg::sound_e   cur_sound,
  output logic                     tone_start,
  output bomb_audio_pkg::tone_t    tone
);

  logic [8:0] secs_left;
  logic tick_req;
  bomb_audio_pkg::sound_e req_sound;
  bomb_audio_pkg::sound_e base_sound;
  bomb_audio_pkg::sound_e nxt_sound;
  logic nxt_start;

  // higher number wins
  function automatic logic [2:0] rank(input bomb_audio_pkg::sound_e s);
    logic [2:0] r;
    case (s)
      bomb_audio_pkg::snd_error:  r = 3'd4;
      bomb_audio_pkg::snd_boom:   r = 3'd3;
      bomb_audio_pkg::snd_puzzle: r = 3'd2;
      bomb_audio_pkg::snd_tick:   r = 3'd1;
      default:                    r = 3'd0;
    endcase
    return r;
  endfunction

  // flat seconds for the rate thresholds
  assign secs_left = 9'(time_left.minutes) * 9'd60
                   + 9'(time_left.sec_ten) * 9'd10
                   + 9'(time_left.sec_one);

  // tick strobe picked strictly below each threshold
  always_comb begin
    if (secs_left < `FASTER_SEC) begin
      tick_req = beat_faster;
    end else if (secs_left < `FAST_SEC) begin
      tick_req = beat_fast;
    end else begin
      tick_req = beat;
    end
  end

  // strongest request this cycle
  always_comb begin
    if (error) begin
      req_sound = bomb_audio_pkg::snd_error;
    end else if (game_clear) begin
      req_sound = bomb_audio_pkg::snd_boom;
    end else if (puzzle_clear) begin
      req_sound = bomb_audio_pkg::snd_puzzle;
    end else if (tick_req) begin
      req_sound = bomb_audio_pkg::snd_tick;
    end else begin
      req_sound = bomb_audio_pkg::snd_idle;
    end
  end

  // a finishing sound no longer blocks anything
  // done of the old tone is stale when a new one was just started
  assign base_sound = (tone_done && !tone_start) ? bomb_audio_pkg::snd_idle : cur_sound;

  // preempt only on strictly higher rank
  // losing requests are dropped
  always_comb begin
    nxt_sound = base_sound;
    nxt_start = 1'b0;
    if (rank(req_sound) > rank(base_sound)) begin
      nxt_sound = req_sound;
      nxt_start = 1'b1;
    end
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      cur_sound  <= bomb_audio_pkg::snd_idle;
      tone_start <= 1'b0;
    end else begin
      cur_sound  <= nxt_sound;
      tone_start <= nxt_start;
    end
  end

  // descriptor follows the registered sound
  // valid in the tone_start cycle
  always_comb begin
    tone = '0;
    case (cur_sound)
      bomb_audio_pkg::snd_error: begin
        tone.half_period = 8'(`ERR_HALF);
        tone.toggles     = 6'(`ERR_TOGGLES);
      end
      bomb_audio_pkg::snd_boom: begin
        tone.half_period = 8'(`BOOM_HALF);
        tone.toggles     = 6'(`BOOM_TOGGLES);
      end
      bomb_audio_pkg::snd_puzzle: begin
        tone.half_period = 8'(`PZL_HALF);
        tone.toggles     = 6'(`PZL_TOGGLES);
      end
      bomb_audio_pkg::snd_tick: begin
        tone.half_period = 8'(`TICK_HALF);
        tone.toggles     = 6'(`TICK_TOGGLES);
      end
      default: begin
        tone = '0;
      end
    endcase
  end

endmodule

/* source/countdown_timer.sv */
`timescale 1ns/1ps

`include "bomb_audio_config.svh"

module countdown_timer (
  input  logic                     clk,
  input  logic                     nrst,
  input  logic                     load,
  input  bomb_audio_pkg::game_time_t start_time,
  output bomb_audio_pkg::game_time_t time_left,
  output logic                     beat,
  output logic                     beat_fast,
  output logic                     beat_faster,
  output logic                     expired
);

  localparam int CNT_W = $clog2(`SEC_CYCLES);
  localparam int FAST_CYCLES = `SEC_CYCLES / `BEAT_FAST_DIV;
  localparam int FASTER_CYCLES = `SEC_CYCLES / `BEAT_FASTER_DIV;

  logic running;
  logic [CNT_W-1:0] sec_cnt;
  logic [CNT_W-1:0] fast_cnt;
  logic [CNT_W-1:0] faster_cnt;
  logic sec_wrap;
  logic fast_wrap;
  logic faster_wrap;
  logic last_sec;
  bomb_audio_pkg::game_time_t time_dec;

  // prescaler end points
  assign sec_wrap = (sec_cnt == CNT_W'(`SEC_CYCLES - 1));
  assign fast_wrap = (fast_cnt == CNT_W'(FAST_CYCLES - 1));
  assign faster_wrap = (faster_cnt == CNT_W'(FASTER_CYCLES - 1));

  // one second less, borrow ones -> tens -> minutes
  always_comb begin
    time_dec = time_left;
    if (time_left.sec_one != 4'd0) begin
      time_dec.sec_one = time_left.sec_one - 4'd1;
    end else begin
      time_dec.sec_one = 4'd9;
      if (time_left.sec_ten != 3'd0) begin
        time_dec.sec_ten = time_left.sec_ten - 3'd1;
      end else begin
        time_dec.sec_ten = 3'd5;
        time_dec.minutes = time_left.minutes - 3'd1;
      end
    end
  end

  // this decrement lands on 0:00
  assign last_sec = (time_dec == '0);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      time_left   <= '0;
      running     <= 1'b0;
      expired     <= 1'b0;
      sec_cnt     <= '0;
      fast_cnt    <= '0;
      faster_cnt  <= '0;
      beat        <= 1'b0;
      beat_fast   <= 1'b0;
      beat_faster <= 1'b0;
    end else begin
      // strobes are single cycle
      beat        <= 1'b0;
      beat_fast   <= 1'b0;
      beat_faster <= 1'b0;
      if (load) begin
        time_left  <= start_time;
        // loading 0:00 counts as already expired
        running    <= (start_time != '0);
        expired    <= (start_time == '0);
        sec_cnt    <= '0;
        fast_cnt   <= '0;
        faster_cnt <= '0;
      end else if (running) begin
        sec_cnt    <= sec_wrap ? '0 : sec_cnt + 1'b1;
        fast_cnt   <= fast_wrap ? '0 : fast_cnt + 1'b1;
        faster_cnt <= faster_wrap ? '0 : faster_cnt + 1'b1;
        // all beats share the last wrap, drop them when time runs out
        beat_fast   <= fast_wrap && !(sec_wrap && last_sec);
        beat_faster <= faster_wrap && !(sec_wrap && last_sec);
        if (sec_wrap) begin
          time_left <= time_dec;
          beat      <= !last_sec;
          if (last_sec) begin
            running <= 1'b0;
            expired <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* source/bomb_audio_pkg.sv */
package bomb_audio_pkg;

  // active sound, priority is not the code order
  // error > boom > puzzle > tick > idle
  typedef enum logic [2:0] {
    snd_idle   = 3'd0,
    snd_error  = 3'd1,
    snd_boom   = 3'd2,
    snd_puzzle = 3'd3,
    snd_tick   = 3'd4
  } sound_e;

  // one square-wave tone
  typedef struct packed {
    // clock cycles per audio half wave
    logic [7:0] half_period;
    // audio edges in the whole sound, always even
    logic [5:0] toggles;
  } tone_t;

  // mixed radix game clock m:ss
  typedef struct packed {
    logic [2:0] minutes;
    // 0..5
    logic [2:0] sec_ten;
    // 0..9
    logic [3:0] sec_one;
  } game_time_t;

endpackage

/* include/bomb_audio_config.svh */
`ifndef BOMB_AUDIO_CONFIG_SVH
`define BOMB_AUDIO_CONFIG_SVH

// clocks per game second, scaled down for simulation
`define SEC_CYCLES 200

// beats per game second of the fast strobes
`define BEAT_FAST_DIV 2
`define BEAT_FASTER_DIV 4

// tick rate thresholds, seconds left
`define FAST_SEC 30
`define FASTER_SEC 20

// error buzz
`define ERR_HALF 5
`define ERR_TOGGLES 12

// boom on game clear
`define BOOM_HALF 7
`define BOOM_TOGGLES 16

// puzzle clear chirp
`define PZL_HALF 4
`define PZL_TOGGLES 8

// countdown tick
`define TICK_HALF 3
`define TICK_TOGGLES 6

`endif
